//--- project.f
skinny_pkg.sv
skinny_sbox8.sv
skinny_round.sv
skinny_tweakey_sched.sv
skinny_core.sv
skinny_core_assert.sv
skinny_core_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the SKINNY core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module skinny_core_tb -f project.f \
   > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/Vskinny_core_tb > sim.log 2>&1
cat sim.log

grep -q "TESTBENCH PASSED" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

//--- skinny_cases.txt
// SKINNY-128-384+ known answers, 40 rounds, cell 0 in the leftmost byte
// Columns: tk1 tk2 tk3 pt ct, each a 128-bit hex word
// The reference vector is repeated so that gaps and back-to-back starts get exercised
df889548cfc7ea52d296339301797449 ab588a34a47f1ab2dfe9c8293fbea9a5 ab1afac2611012cd8cef952618c3ebe8 a3994b66ad85a3459f44e92b08f550cb ff38d1d24c864c4352a853690fe36e5e
df889548cfc7ea52d296339301797449 ab588a34a47f1ab2dfe9c8293fbea9a5 ab1afac2611012cd8cef952618c3ebe8 a3994b66ad85a3459f44e92b08f550cb ff38d1d24c864c4352a853690fe36e5e
df889548cfc7ea52d296339301797449 ab588a34a47f1ab2dfe9c8293fbea9a5 ab1afac2611012cd8cef952618c3ebe8 a3994b66ad85a3459f44e92b08f550cb ff38d1d24c864c4352a853690fe36e5e
df889548cfc7ea52d296339301797449 ab588a34a47f1ab2dfe9c8293fbea9a5 ab1afac2611012cd8cef952618c3ebe8 a3994b66ad85a3459f44e92b08f550cb ff38d1d24c864c4352a853690fe36e5e

//--- skinny_core.sv
`timescale 1ns/1ps

module skinny_core import skinny_pkg::*; #(
   parameter int ROUNDS = 40
) (
   input  logic   clk,
   input  logic   rst_n,
   input  logic   start,
   input  block_t pt,
   input  block_t tk1,
   input  block_t tk2,
   input  block_t tk3,
   output block_t ct,
   output logic   done,
   output logic   busy
);

   localparam int CNT_W = (ROUNDS > 1) ? $clog2(ROUNDS) : 1;
   localparam logic [CNT_W-1:0] LAST_RND = CNT_W'(ROUNDS - 1);

   core_state_t      ctrl_q;
   block_t           state_q;
   block_t           state_nxt;
   half_t            round_key;
   logic [CNT_W-1:0] rnd_cnt;
   logic             accept;
   logic             last_rnd;

   assign busy     = (ctrl_q == ST_RUN);
   assign accept   = start && !busy;   // Starts while running are dropped
   assign last_rnd = busy && (rnd_cnt == LAST_RND);

   skinny_round round_i (
      .state_in  (state_q),
      .round_key (round_key),
      .state_out (state_nxt)
   );

   skinny_tweakey_sched tks_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .load      (accept),
      .advance   (busy),
      .tk1_in    (tk1),
      .tk2_in    (tk2),
      .tk3_in    (tk3),
      .round_key (round_key)
   );

   // Controller and round count
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ctrl_q  <= ST_IDLE;
         rnd_cnt <= '0;
         done    <= 1'b0;
      end else begin
         done <= last_rnd;
         case (ctrl_q)
            ST_IDLE: begin
               if (accept) begin
                  ctrl_q  <= ST_RUN;
                  rnd_cnt <= '0;
               end
            end
            ST_RUN: begin
               if (last_rnd) begin
                  ctrl_q <= ST_IDLE;
               end else begin
                  rnd_cnt <= rnd_cnt + CNT_W'(1);
               end
            end
            default: ctrl_q <= ST_IDLE;
         endcase
      end
   end

   // Cipher state advances one round per cycle
   always_ff @(posedge clk) begin
      if (accept) begin
         state_q <= pt;
      end else if (busy) begin
         state_q <= state_nxt;
      end
   end

   // Result held until the next accepted start
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ct <= '0;
      end else if (last_rnd) begin
         ct <= state_nxt;
      end
   end

endmodule

//--- skinny_core_assert.sv
`timescale 1ns/1ps

module skinny_core_assert (
   input logic clk,
   input logic rst_n,
   input logic done,
   input logic busy
);

   // Done is a single-cycle strobe
   done_single: assert property (
      @(posedge clk) disable iff (!rst_n) done |=> !done
   ) else $error("done was high on two consecutive cycles");

   done_busy_excl: assert property (
      @(posedge clk) disable iff (!rst_n) !(done && busy)
   ) else $error("done and busy were high together");

   // End of a run, both edges at once
   busy_fall_done: assert property (
      @(posedge clk) disable iff (!rst_n) $fell(busy) |-> $rose(done)
   ) else $error("busy fell without done rising");

   done_rise_busy: assert property (
      @(posedge clk) disable iff (!rst_n) $rose(done) |-> $fell(busy)
   ) else $error("done rose without busy falling");

endmodule

bind skinny_core skinny_core_assert assert_i (
   .clk   (clk),
   .rst_n (rst_n),
   .done  (done),
   .busy  (busy)
);

//--- skinny_core_tb.sv
`timescale 1ns/1ps

module skinny_core_tb import skinny_pkg::*; ();

   localparam int ROUNDS     = 40;
   localparam int RST_CYCLES = 16;
   localparam int MAX_CASES  = 16;
   localparam int MAX_GAP    = 12;
   localparam int WORDS      = 5;   // tk1 tk2 tk3 pt ct

   logic   clk;
   logic   rst_n;
   logic   start;
   block_t pt;
   block_t tk1;
   block_t tk2;
   block_t tk3;
   block_t ct;
   logic   done;
   logic   busy;

   block_t      vec [WORDS*MAX_CASES];
   int          num_cases;
   int          errors;
   int          checks;
   logic [31:0] seed;

   skinny_core #(
      .ROUNDS (ROUNDS)
   ) dut_i (
      .clk   (clk),
      .rst_n (rst_n),
      .start (start),
      .pt    (pt),
      .tk1   (tk1),
      .tk2   (tk2),
      .tk3   (tk3),
      .ct    (ct),
      .done  (done),
      .busy  (busy)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Differs per address, so entries the file did not fill stand out
   function automatic block_t fill_word(input int addr);
      return {4{32'(addr) ^ 32'h5a3c_96e1}};
   endfunction

   task automatic next_rand(output logic [31:0] r);
      seed = xorshift32(seed);
      r = seed;
   endtask

   task automatic random_block(output block_t b);
      logic [31:0] r;
      for (int i = 0; i < 4; i++) begin
         next_rand(r);
         b[127-32*i -: 32] = r;
      end
   endtask

   task automatic compare(input string name, input block_t exp, input block_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
      end
   endtask

   // Junk on the data inputs while idle
   task automatic scramble_inputs();
      start = 1'b0;
      random_block(pt);
      random_block(tk1);
      random_block(tk2);
      random_block(tk3);
   endtask

   task automatic idle_gap(input int cycles, input block_t held);
      for (int g = 0; g < cycles; g++) begin
         @(negedge clk);
         scramble_inputs();
         compare("done", 128'(0), 128'(done));
         compare("ct", held, ct);
      end
   endtask

   task automatic run_case(input int idx);
      int          base;
      int          lat;
      int          busy_cnt;
      int          extra_at;
      int          err_before;
      logic [31:0] r;
      base = WORDS * idx;
      err_before = errors;
      next_rand(r);
      extra_at = 1 + int'(r % 32'(ROUNDS - 2));
      compare("busy", 128'(0), 128'(busy));
      start = 1'b1;
      tk1 = vec[base];
      tk2 = vec[base + 1];
      tk3 = vec[base + 2];
      pt  = vec[base + 3];
      @(negedge clk);
      lat = 0;
      busy_cnt = 0;
      while (!done && lat <= ROUNDS + 4) begin
         if (busy) begin
            busy_cnt++;
         end
         if (lat == extra_at) begin
            scramble_inputs();
            start = 1'b1;   // Must be ignored, core is running
         end else begin
            start = 1'b0;
         end
         @(negedge clk);
         lat++;
      end
      if (!done) begin
         errors++;
         $display("case %0d: done did not come within %0d cycles of start", idx, ROUNDS + 5);
      end else begin
         compare("ct", vec[base + 4], ct);
         compare("done latency", 128'(ROUNDS), 128'(lat));
         compare("busy cycles", 128'(ROUNDS), 128'(busy_cnt));
         compare("busy", 128'(0), 128'(busy));
      end
      $display("case %0d: %s, done after %0d cycles, extra start at cycle %0d",
               idx, (errors == err_before) ? "ok" : "fail", lat, extra_at);
   endtask

   initial begin
      int          gap;
      logic [31:0] r;
      block_t      last_ct;
      seed      = 32'hfb96_c89c;
      errors    = 0;
      checks    = 0;
      num_cases = 0;
      rst_n     = 1'b0;
      start     = 1'b0;
      pt        = '0;
      tk1       = '0;
      tk2       = '0;
      tk3       = '0;
      for (int a = 0; a < WORDS * MAX_CASES; a++) begin
         vec[a] = fill_word(a);
      end
      $readmemh("skinny_cases.txt", vec);
      while (num_cases < MAX_CASES &&
             vec[WORDS*num_cases] != fill_word(WORDS*num_cases)) begin
         num_cases++;
      end

      repeat (RST_CYCLES) @(negedge clk);
      rst_n = 1'b1;
      compare("done", 128'(0), 128'(done));
      compare("busy", 128'(0), 128'(busy));
      compare("ct", 128'(0), ct);

      if (num_cases == 0) begin
         errors++;
         $display("No cases were read from skinny_cases.txt");
      end
      last_ct = '0;
      for (int i = 0; i < num_cases; i++) begin
         next_rand(r);
         // Odd cases start in the done cycle of the one before
         gap = (i % 2 == 1) ? 0 : 1 + int'(r % 32'(MAX_GAP));
         idle_gap(gap, last_ct);
         run_case(i);
         last_ct = vec[WORDS*i + 4];
      end
      idle_gap(4, last_ct);

      $display("Summary: %0d cases, %0d checks, %0d errors", num_cases, checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   // Watchdog, sized from the case count read at time zero
   initial begin
      int limit;
      #1;
      limit = RST_CYCLES + num_cases * (ROUNDS + MAX_GAP + 4) + MAX_GAP;
      repeat (limit) @(posedge clk);
      $display("Timeout: the run was still going after %0d clock cycles", limit);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

//--- skinny_pkg.sv
package skinny_pkg;

   // State and tweakey word, cell 0 in the top byte
   typedef logic [127:0] block_t;

   // Upper two rows of a tweakey word
   typedef logic [63:0] half_t;

   // One cell of the 4x4 state
   typedef logic [7:0] cell_t;

   // Round constant LFSR
   typedef logic [5:0] rc_t;

   // Controller states
   typedef enum logic {
      ST_IDLE,
      ST_RUN
   } core_state_t;

   // Basic cell of the logic S-box
   function automatic logic sbox_cfn(
      input logic x,
      input logic y,
      input logic z
   );
      logic nor_xy;
      nor_xy = ~(x | y);
      return nor_xy ^ z;
   endfunction

endpackage

//--- skinny_round.sv
`timescale 1ns/1ps

module skinny_round import skinny_pkg::*; (
   input  block_t state_in,
   input  half_t  round_key,
   output block_t state_out
);

   typedef logic [31:0] row_t;

   // Third round constant, fixed 0x02 in cell 8
   localparam block_t C2 = {64'h0, 8'h02, 56'h0};

   block_t sb;
   block_t atk;
   row_t   shr [4];
   row_t   mxc [4];

   // SubCells
   for (genvar j = 0; j < 16; j++) begin : g_sbox
      skinny_sbox8 sbox_i (
         .si (state_in[127-8*j -: 8]),
         .so (sb[127-8*j -: 8])
      );
   end

   // AddRoundTweakey on rows 0 and 1, constant into row 2
   assign atk = sb ^ {round_key, 64'h0} ^ C2;

   // ShiftRows
   assign shr[0] = atk[127:96];
   assign shr[1] = {atk[71:64], atk[95:72]};   // Right by one cell
   assign shr[2] = {atk[47:32], atk[63:48]};   // Right by two
   assign shr[3] = {atk[23:0], atk[31:24]};    // Right by three

   // MixColumns, binary matrix applied per column
   assign mxc[1] = shr[0];
   assign mxc[2] = shr[1] ^ shr[2];
   assign mxc[3] = shr[0] ^ shr[2];
   assign mxc[0] = shr[3] ^ mxc[3];   // Reuses row 3 sum

   assign state_out = {mxc[0], mxc[1], mxc[2], mxc[3]};

endmodule

//--- skinny_sbox8.sv
`timescale 1ns/1ps

module skinny_sbox8 import skinny_pkg::*; (
   input  cell_t si,
   output cell_t so
);

   cell_t a;

   // Eight chained steps, each feeding later ones
   assign a[0] = sbox_cfn(si[7], si[6], si[4]);
   assign a[1] = sbox_cfn(si[3], si[2], si[0]);
   assign a[2] = sbox_cfn(si[2], si[1], si[6]);
   assign a[3] = sbox_cfn(a[0], a[1], si[5]);
   assign a[4] = sbox_cfn(a[1], si[3], si[1]);
   assign a[5] = sbox_cfn(a[2], a[3], si[7]);
   assign a[6] = sbox_cfn(a[3], a[0], si[3]);
   assign a[7] = sbox_cfn(a[4], a[5], si[2]);

   // Final bit shuffle
   assign so[7] = a[3];
   assign so[6] = a[0];
   assign so[5] = a[1];
   assign so[4] = a[6];
   assign so[3] = a[4];
   assign so[2] = a[2];
   assign so[1] = a[5];
   assign so[0] = a[7];   // S(0x00) comes out as 0x65

endmodule

//--- skinny_tweakey_sched.sv
`timescale 1ns/1ps

module skinny_tweakey_sched import skinny_pkg::*; (
   input  logic   clk,
   input  logic   rst_n,
   input  logic   load,
   input  logic   advance,
   input  block_t tk1_in,
   input  block_t tk2_in,
   input  block_t tk3_in,
   output half_t  round_key
);

   // New cell i is old cell PT[i]
   localparam int unsigned PT [16] = '{
      9, 15, 8, 13, 10, 14, 12, 11,
      0, 1, 2, 3, 4, 5, 6, 7
   };

   block_t tk1_q;
   block_t tk2_q;
   block_t tk3_q;
   block_t tk1_p;
   block_t tk2_p;
   block_t tk3_p;
   rc_t    rc_q;
   rc_t    rc_nxt;
   half_t  rc_pat;

   function automatic block_t tk_perm(input block_t ki);
      block_t ko;
      for (int i = 0; i < 16; i++) begin
         ko[127-8*i -: 8] = ki[127-8*PT[i] -: 8];
      end
      return ko;
   endfunction

   // TK2 cell LFSR, shift left
   function automatic half_t lfsr2(input half_t hi);
      half_t ho;
      cell_t c;
      for (int i = 0; i < 8; i++) begin
         c = hi[63-8*i -: 8];
         ho[63-8*i -: 8] = {c[6:0], c[7] ^ c[5]};
      end
      return ho;
   endfunction

   // TK3 cell LFSR, shift right
   function automatic half_t lfsr3(input half_t hi);
      half_t ho;
      cell_t c;
      for (int i = 0; i < 8; i++) begin
         c = hi[63-8*i -: 8];
         ho[63-8*i -: 8] = {c[0] ^ c[6], c[7:1]};
      end
      return ho;
   endfunction

   // Next round constant, first round sees 6'h01
   assign rc_nxt = {rc_q[4:0], rc_q[5] ^ rc_q[4] ^ 1'b1};

   assign tk1_p = tk_perm(tk1_q);
   assign tk2_p = tk_perm(tk2_q);
   assign tk3_p = tk_perm(tk3_q);

   // Constants land in cells 0 and 4
   assign rc_pat = {4'h0, rc_nxt[3:0], 24'h0, 6'h0, rc_nxt[5:4], 24'h0};

   assign round_key = tk1_q[127:64] ^ tk2_q[127:64] ^ tk3_q[127:64] ^ rc_pat;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rc_q <= '0;
      end else if (load) begin
         rc_q <= '0;
      end else if (advance) begin
         rc_q <= rc_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         tk1_q <= tk1_in;
         tk2_q <= tk2_in;
         tk3_q <= tk3_in;
      end else if (advance) begin
         tk1_q <= tk1_p;   // TK1 is only permuted
         tk2_q <= {lfsr2(tk2_p[127:64]), tk2_p[63:0]};
         tk3_q <= {lfsr3(tk3_p[127:64]), tk3_p[63:0]};
      end
   end

endmodule
